/* list.f */
logic/mem_pkg.sv
logic/req_queue.sv
logic/mem_cmd_cntr.sv
logic/load_extract.sv
logic/mem_access_top.sv
tb/mem_model.sv
tb/tb_mem_access.sv

/* tb/tb_mem_access.sv */
module tb_mem_access
    import mem_pkg::*;
();

    localparam int          QUEUE_DEPTH    = 4;
    localparam int          STALL_PCT      = 30;
    localparam int          N_RANDOM       = 300;
    localparam int          MAX_CMDS       = N_RANDOM + 64;
    localparam int          CYCLES_PER_CMD = 40;
    localparam int          CLK_PERIOD     = 4;
    localparam logic [31:0] BASE           = 32'h0000_0100;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    core_cmd_t   cmd;
    logic        cmd_ready;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_resp_valid;
    logic [31:0] mem_resp_rdata;
    logic        ld_valid;
    logic [31:0] ld_addr;
    logic [31:0] ld_data;
    logic        hold_off;
    logic        seen_edge;
    logic [31:0] lcg_state;
    logic [31:0] shadow [16];
    logic [31:0] exp_ld_data_q [$];
    logic [31:0] exp_ld_addr_q [$];
    mem_req_t    exp_mreq_q [$];
    logic [31:0] exp_ld_data;
    logic [31:0] exp_ld_addr;
    mem_req_t    exp_mreq;
    logic [31:0] exp_mask;
    int          ld_pending;
    int          mreq_pending;

    mem_access_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_data        (ld_data)
    );

    mem_model #(
        .STALL_PCT (STALL_PCT)
    ) mem0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold_off       (hold_off),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    // memory request that a command should produce, with data only on its own lanes
    function automatic mem_req_t expected_mem_req(input core_cmd_t c);
        mem_req_t m;
        m.wen   = 1'b0;
        m.addr  = {c.addr[31:2], 2'b00};
        m.wstrb = 4'b0000;
        m.wdata = '0;
        case (c.op)
            op_sb: begin
                m.wen   = 1'b1;
                m.wstrb = 4'b0001 << c.addr[1:0];
                m.wdata = {24'd0, c.wdata[7:0]} << (8 * c.addr[1:0]);
            end
            op_sh: begin
                m.wen   = 1'b1;
                m.wstrb = c.addr[1] ? 4'b1100 : 4'b0011;
                m.wdata = c.addr[1] ? {c.wdata[15:0], 16'd0} : {16'd0, c.wdata[15:0]};
            end
            op_sw: begin
                m.wen   = 1'b1;
                m.wstrb = 4'b1111;
                m.wdata = c.wdata;
            end
            default: begin
            end
        endcase
        return m;
    endfunction

    function automatic logic [31:0] expected_load(input mem_op_t op, input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = shadow[addr[5:2]];
        b    = 8'(word >> (8 * addr[1:0]));
        h    = addr[1] ? word[31:16] : word[15:0];
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'd0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at time %0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic update_heads();
        exp_mreq     = exp_mreq_q.size() > 0 ? exp_mreq_q[0] : '0;
        exp_mask     = lane_mask(exp_mreq.wstrb);
        exp_ld_data  = exp_ld_data_q.size() > 0 ? exp_ld_data_q[0] : '0;
        exp_ld_addr  = exp_ld_addr_q.size() > 0 ? exp_ld_addr_q[0] : '0;
        mreq_pending = exp_mreq_q.size();
        ld_pending   = exp_ld_data_q.size();
    endtask

    task automatic next_rand(output logic [31:0] r);
        lcg_state = lcg_next(lcg_state);
        r         = lcg_state >> 12;
    endtask

    // shadow memory follows command order, which is also the completion order
    task automatic note_accept(input core_cmd_t c);
        mem_req_t    m;
        logic [31:0] mask;
        m = expected_mem_req(c);
        exp_mreq_q.push_back(m);
        if (m.wen) begin
            mask                 = lane_mask(m.wstrb);
            shadow[c.addr[5:2]] = (shadow[c.addr[5:2]] & ~mask) | (m.wdata & mask);
        end else begin
            exp_ld_data_q.push_back(expected_load(c.op, c.addr));
            exp_ld_addr_q.push_back(c.addr);
        end
        update_heads();
    endtask

    task automatic send_cmd(input mem_op_t op, input logic [31:0] addr, input logic [31:0] wdata);
        core_cmd_t c;
        logic      taken;
        c.op      = op;
        c.addr    = addr;
        c.wdata   = wdata;
        cmd       = c;
        cmd_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            taken = cmd_ready;
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b0;
        note_accept(c);
    endtask

    task automatic build_random_cmd(output core_cmd_t c);
        logic [31:0] r;
        logic [31:0] d;
        logic [1:0]  off;
        next_rand(r);
        next_rand(d);
        c.op = mem_op_t'(r[2:0]);
        case (c.op)
            op_lh, op_lhu, op_sh: off = {r[4], 1'b0};
            op_lw, op_sw:         off = 2'b00;
            default:              off = r[4:3];
        endcase
        c.addr  = BASE + {26'd0, r[9:6], off};
        c.wdata = {d[19:0], r[19:8]};
    endtask

    task automatic drain();
        while (exp_mreq_q.size() != 0 || exp_ld_data_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic fill_queue_under_stall();
        core_cmd_t c;
        int        n_taken;
        drain();
        hold_off = 1'b1;
        @(posedge clk);
        #1;
        n_taken = 0;
        while (cmd_ready) begin
            build_random_cmd(c);
            cmd       = c;
            cmd_valid = 1'b1;
            @(posedge clk);
            #1;
            note_accept(c);
            n_taken++;
        end
        cmd_valid = 1'b0;
        // one command sits in the controller, the rest fill the queue
        assert (n_taken == QUEUE_DEPTH + 1) else
            report_failure($sformatf("cmd_ready dropped after %0d commands instead of %0d",
                                     n_taken, QUEUE_DEPTH + 1));
        repeat (8) @(posedge clk);
        #1;
        hold_off = 1'b0;
        drain();
    endtask

    always @(posedge clk) begin
        seen_edge = 1'b1;
        if (rst_n && mem_req_valid && mem_req_ready && exp_mreq_q.size() > 0) begin
            void'(exp_mreq_q.pop_front());
        end
        if (rst_n && ld_valid && exp_ld_data_q.size() > 0) begin
            void'(exp_ld_data_q.pop_front());
            void'(exp_ld_addr_q.pop_front());
        end
        update_heads();
    end

    reset_idle: assert property (@(posedge clk)
        (seen_edge && (!rst_n || $rose(rst_n))) |-> (!mem_req_valid && !ld_valid && cmd_ready))
        else report_failure("outputs were not idle during or right after reset");

    load_expected: assert property (@(posedge clk) disable iff (!rst_n)
        ld_valid |-> ld_pending > 0)
        else report_failure("a load result arrived with no load outstanding");

    load_data: assert property (@(posedge clk) disable iff (!rst_n)
        ld_valid |-> ld_data == exp_ld_data)
        else report_mismatch("ld_data", $sampled(exp_ld_data), $sampled(ld_data));

    load_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ld_valid |-> ld_addr == exp_ld_addr)
        else report_mismatch("ld_addr", $sampled(exp_ld_addr), $sampled(ld_addr));

    mreq_expected: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready) |-> mreq_pending > 0)
        else report_failure("a memory request went out with no command behind it");

    mreq_wen: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready) |-> mem_req.wen == exp_mreq.wen)
        else report_mismatch("mem_req.wen", $sampled(exp_mreq.wen), $sampled(mem_req.wen));

    mreq_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready) |-> mem_req.addr == exp_mreq.addr)
        else report_mismatch("mem_req.addr", $sampled(exp_mreq.addr), $sampled(mem_req.addr));

    mreq_wstrb: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready) |-> mem_req.wstrb == exp_mreq.wstrb)
        else report_mismatch("mem_req.wstrb", $sampled(exp_mreq.wstrb), $sampled(mem_req.wstrb));

    mreq_wdata: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && mem_req_ready) |-> (mem_req.wdata & exp_mask) == exp_mreq.wdata)
        else report_mismatch("mem_req.wdata", $sampled(exp_mreq.wdata),
                             $sampled(mem_req.wdata & exp_mask));

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else report_failure("mem_req changed or dropped while memory was stalling");

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (20 + MAX_CMDS * CYCLES_PER_CMD));
        $display("ERROR at time %0t: watchdog expired before all commands completed", $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        core_cmd_t c;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        hold_off  = 1'b0;
        seen_edge = 1'b0;
        lcg_state = 32'h574e;
        update_heads();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < 16; i++) begin
            next_rand(c.wdata);
            send_cmd(op_sw, BASE + 4 * i, {c.wdata[19:0], 12'h3c5});
        end
        send_cmd(op_sw, BASE + 4, 32'h1234_5678);
        send_cmd(op_lw, BASE + 4, '0);
        for (int off = 0; off < 4; off++) begin
            send_cmd(op_sb, BASE + 8 + off, 32'hffff_ff80 | off);
        end
        send_cmd(op_lw, BASE + 8, '0);
        send_cmd(op_sh, BASE + 12, 32'h0000_a55a);
        send_cmd(op_sh, BASE + 14, 32'hffff_3cc3);
        send_cmd(op_lw, BASE + 12, '0);
        // bytes 01 ff 80 7f and halfwords ff01 7f80 cover both top-bit cases
        send_cmd(op_sw, BASE + 16, 32'h7f80_ff01);
        for (int off = 0; off < 4; off++) begin
            send_cmd(op_lb, BASE + 16 + off, '0);
            send_cmd(op_lbu, BASE + 16 + off, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            send_cmd(op_lh, BASE + 16 + off, '0);
            send_cmd(op_lhu, BASE + 16 + off, '0);
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            build_random_cmd(c);
            send_cmd(c.op, c.addr, c.wdata);
        end
        fill_queue_under_stall();
        drain();
        repeat (4) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb/mem_model.sv */
module mem_model
    import mem_pkg::*;
#(
    parameter int STALL_PCT = 30,
    parameter int WORDS     = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold_off,
    input  logic        mem_req_valid,
    input  mem_req_t    mem_req,
    output logic        mem_req_ready,
    output logic        mem_resp_valid,
    output logic [31:0] mem_resp_rdata
);

    localparam int IDX_W        = $clog2(WORDS);
    localparam int STALL_THRESH = STALL_PCT * 256 / 100;

    logic [31:0]      words [WORDS];
    logic [31:0]      lcg_state;
    logic [31:0]      read_word;
    logic [1:0]       delay;
    logic             pending;
    logic [IDX_W-1:0] idx;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign idx = mem_req.addr[IDX_W+1:2];

    // each word starts out holding its own byte address
    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        for (int i = 0; i < WORDS; i++) begin
            words[i] = {16'h5a5a, 16'(i * 4)};
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            lcg_state      <= 32'h574e;
            mem_req_ready  <= 1'b0;
            mem_resp_valid <= 1'b0;
            mem_resp_rdata <= '0;
            pending        <= 1'b0;
            delay          <= '0;
        end else begin
            lcg_state      <= lcg_next(lcg_state);
            mem_req_ready  <= !hold_off && (lcg_state[31:24] >= STALL_THRESH);
            mem_resp_valid <= 1'b0;
            if (pending) begin
                if (delay == 2'd0) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_rdata <= read_word;
                    pending        <= 1'b0;
                end else begin
                    delay <= delay - 1'b1;
                end
            end
            // a read accepted here waits 1 to 4 cycles before its response pulse
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.wen) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_req.wstrb[b]) begin
                            words[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    read_word <= words[idx];
                    pending   <= 1'b1;
                    delay     <= lcg_state[21:20];
                end
            end
        end
    end

endmodule

/* logic/mem_access_top.sv */
module mem_access_top
    import mem_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cmd_valid,
    input  core_cmd_t   cmd,
    output logic        cmd_ready,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_req_ready,
    input  logic        mem_resp_valid,
    input  logic [31:0] mem_resp_rdata,
    output logic        ld_valid,
    output logic [31:0] ld_addr,
    output logic [31:0] ld_data
);

    logic        req_valid;
    logic        req_ready;
    d_request_t  req;
    logic        dresp_valid;
    d_response_t dresp;

    req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_req_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

    mem_cmd_cntr u_mem_cmd_cntr (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .dresp_valid    (dresp_valid),
        .dresp          (dresp)
    );

    load_extract u_load_extract (
        .clk         (clk),
        .rst_n       (rst_n),
        .dresp_valid (dresp_valid),
        .dresp       (dresp),
        .ld_valid    (ld_valid),
        .ld_addr     (ld_addr),
        .ld_data     (ld_data)
    );

endmodule

/* logic/load_extract.sv */
module load_extract
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dresp_valid,
    input  d_response_t dresp,
    output logic        ld_valid,
    output logic [31:0] ld_addr,
    output logic [31:0] ld_data
);

    d_response_t resp_q;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= dresp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dresp_valid) begin
            resp_q <= dresp;
        end
    end

    always_comb begin
        case (resp_q.addr[1:0])
            2'd0:    sel_byte = resp_q.rdata[7:0];
            2'd1:    sel_byte = resp_q.rdata[15:8];
            2'd2:    sel_byte = resp_q.rdata[23:16];
            default: sel_byte = resp_q.rdata[31:24];
        endcase
    end

    // matches the lane pair the queue uses for halfword stores
    assign sel_half = resp_q.addr[1] ? resp_q.rdata[31:16] : resp_q.rdata[15:0];

    always_comb begin
        case (resp_q.op)
            op_lb:   ld_data = {{24{sel_byte[7]}}, sel_byte};
            op_lbu:  ld_data = {24'd0, sel_byte};
            op_lh:   ld_data = {{16{sel_half[15]}}, sel_half};
            op_lhu:  ld_data = {16'd0, sel_half};
            default: ld_data = resp_q.rdata;
        endcase
    end

    assign ld_addr = resp_q.addr;

endmodule

/* logic/mem_cmd_cntr.sv */
module mem_cmd_cntr
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  d_request_t  req,
    output logic        req_ready,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_req_ready,
    input  logic        mem_resp_valid,
    input  logic [31:0] mem_resp_rdata,
    output logic        dresp_valid,
    output d_response_t dresp
);

    ctrl_state_t state;
    ctrl_state_t issue_state;
    d_request_t  saved_req;
    logic        take;

    function automatic mem_req_t to_mem(input d_request_t r);
        mem_req_t m;
        m.wen   = r.wen;
        m.addr  = r.addr;
        m.wstrb = r.wstrb;
        m.wdata = r.wdata;
        return m;
    endfunction

    // the live request drives memory except while a stalled one is held
    always_comb begin
        req_ready     = 1'b0;
        mem_req_valid = 1'b0;
        mem_req       = to_mem(req);
        case (state)
            wait_cmd: begin
                req_ready     = 1'b1;
                mem_req_valid = req_valid;
            end
            wait_ready: begin
                mem_req_valid = 1'b1;
                mem_req       = to_mem(saved_req);
            end
            wait_read_valid: begin
                // a new request may go out in the same cycle the read returns
                req_ready     = mem_resp_valid;
                mem_req_valid = req_valid && mem_resp_valid;
            end
            default: begin
                req_ready     = 1'b0;
                mem_req_valid = 1'b0;
            end
        endcase
    end

    assign take = req_valid && req_ready;

    always_comb begin
        if (!mem_req_ready) begin
            issue_state = wait_ready;
        end else if (req.wen) begin
            issue_state = wait_cmd;
        end else begin
            issue_state = wait_read_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= wait_cmd;
        end else begin
            case (state)
                wait_cmd: begin
                    if (take) begin
                        state <= issue_state;
                    end
                end
                wait_ready: begin
                    if (mem_req_ready) begin
                        state <= saved_req.wen ? wait_cmd : wait_read_valid;
                    end
                end
                wait_read_valid: begin
                    if (mem_resp_valid) begin
                        state <= take ? issue_state : wait_cmd;
                    end
                end
                default: begin
                    state <= wait_cmd;
                end
            endcase
        end
    end

    // holds the request through a stall and keeps op and address for the read
    always_ff @(posedge clk) begin
        if (take) begin
            saved_req <= req;
        end
    end

    assign dresp_valid = (state == wait_read_valid) && mem_resp_valid;
    assign dresp.addr  = {saved_req.addr[31:2], saved_req.byte_off};
    assign dresp.rdata = mem_resp_rdata;
    assign dresp.op    = saved_req.op;

endmodule

/* logic/req_queue.sv */
module req_queue
    import mem_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_valid,
    input  core_cmd_t  cmd,
    output logic       cmd_ready,
    output logic       req_valid,
    output d_request_t req,
    input  logic       req_ready
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

    d_request_t        entries [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              push;
    logic              pop;
    d_request_t        push_req;

    // turns a core command into a lane-aligned memory request
    function automatic d_request_t convert(input core_cmd_t c);
        d_request_t r;
        logic [1:0] off;
        off        = c.addr[1:0];
        r.addr     = {c.addr[31:2], 2'b00};
        r.op       = c.op;
        r.byte_off = off;
        case (c.op)
            op_sb: begin
                r.wen   = 1'b1;
                r.wstrb = 4'b0001 << off;
                r.wdata = {4{c.wdata[7:0]}};
            end
            op_sh: begin
                // halfwords use the lane pair picked by bit 1 of the offset
                r.wen   = 1'b1;
                r.wstrb = 4'b0011 << {off[1], 1'b0};
                r.wdata = {2{c.wdata[15:0]}};
            end
            op_sw: begin
                r.wen   = 1'b1;
                r.wstrb = 4'b1111;
                r.wdata = c.wdata;
            end
            default: begin
                r.wen   = 1'b0;
                r.wstrb = 4'b0000;
                r.wdata = '0;
            end
        endcase
        return r;
    endfunction

    assign cmd_ready = count != FULL_COUNT;
    assign req_valid = count != '0;
    assign req       = entries[rd_ptr];

    assign push     = cmd_valid && cmd_ready;
    assign pop      = req_valid && req_ready;
    assign push_req = convert(cmd);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

    // access opcodes seen on the core command port
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lbu = 3'd1,
        op_lh  = 3'd2,
        op_lhu = 3'd3,
        op_lw  = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_t;

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } core_cmd_t;

    // addr is word aligned here, the low bits travel in byte_off
    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        mem_op_t     op;
        logic [1:0]  byte_off;
    } d_request_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] rdata;
        mem_op_t     op;
    } d_response_t;

    typedef struct packed {
        logic        wen;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        wait_cmd,
        wait_ready,
        wait_read_valid
    } ctrl_state_t;

endpackage
